// File: mips_defines.svh
/* mips32 decode widths */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// raw instruction word
`define INST_W      32

// instruction fields
`define OPCODE_W    6
`define FUNCT_W     6
`define REG_IDX_W   5
`define IMM_W       16
`define TARGET_W    26

// datapath word, extended immediate
`define DATA_W      32

// decoded identifier
`define INST_ID_W   8

`endif

// File: mips_isa_pkg.sv
/* mips32 encoding field types */
`default_nettype none

`include "mips_defines.svh"

package mips_isa_pkg;

    // whole instruction as fetched
    typedef logic [`INST_W-1:0] inst_code_t;

    // primary opcode, bits 31:26
    typedef logic [`OPCODE_W-1:0] opcode_t;

    // SPECIAL function field, bits 5:0
    typedef logic [`FUNCT_W-1:0] funct_t;

    // gpr index for rs, rt and rd
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // shift amount, bits 10:6
    typedef logic [`REG_IDX_W-1:0] shamt_t;

    // raw immediate, bits 15:0
    typedef logic [`IMM_W-1:0] imm16_t;

    // immediate after extension
    typedef logic [`DATA_W-1:0] word_t;

    // J and JAL index, bits 25:0
    typedef logic [`TARGET_W-1:0] jtarget_t;

endpackage

`default_nettype wire

// File: id_dec_pkg.sv
/* decoded instruction identifiers */
`default_nettype none

`include "mips_defines.svh"

package id_dec_pkg;

    // invalid must stay at zero, the output register resets to it
    typedef enum logic [`INST_ID_W-1:0] {
        INST_INVALID = 0,
        // SPECIAL group
        INST_SLL, INST_SRL, INST_SRA,
        INST_SLLV, INST_SRLV, INST_SRAV,
        INST_JR, INST_JALR,
        INST_SYSCALL, INST_BREAK,
        INST_MFHI, INST_MTHI, INST_MFLO, INST_MTLO,
        INST_MULT, INST_MULTU, INST_DIV, INST_DIVU,
        INST_ADD, INST_ADDU, INST_SUB, INST_SUBU,
        INST_AND, INST_OR, INST_XOR, INST_NOR,
        INST_SLT, INST_SLTU,
        // REGIMM branches
        INST_BLTZ, INST_BGEZ, INST_BLTZAL, INST_BGEZAL,
        // branches on opcode
        INST_BEQ, INST_BNE, INST_BLEZ, INST_BGTZ,
        // alu immediates
        INST_ADDI, INST_ADDIU, INST_SLTI, INST_SLTIU,
        INST_ANDI, INST_ORI, INST_XORI, INST_LUI,
        // coprocessor 0
        INST_MFC0, INST_MTC0,
        INST_TLBR, INST_TLBWI, INST_TLBP, INST_ERET, INST_WAIT,
        // loads and stores
        INST_LB, INST_LH, INST_LWL, INST_LW, INST_LBU, INST_LHU, INST_LWR,
        INST_SB, INST_SH, INST_SWL, INST_SW, INST_SWR,
        INST_CACHE, INST_PREF,
        // jumps
        INST_J, INST_JAL
    } inst_t;

    // encoding format of the decoded word
    typedef enum logic [1:0] {
        FMT_NONE = 2'd0,
        FMT_R    = 2'd1,
        FMT_I    = 2'd2,
        FMT_J    = 2'd3
    } inst_fmt_t;

endpackage

`default_nettype wire

// File: id_r.sv
/* R-type decoder */
`timescale 1ns/100ps
`default_nettype none

module id_r
    import mips_isa_pkg::*, id_dec_pkg::*;
(
    input  inst_code_t inst_code,
    output inst_t      inst_r
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rs_field;

    assign opcode   = inst_code[31:26];
    assign funct    = inst_code[5:0];
    assign rs_field = inst_code[25:21];

    always_comb
    begin
        inst_r = INST_INVALID;
        // only the SPECIAL opcode carries a funct field
        if (opcode == 6'h00)
        begin
            case (funct)
                // shift by shamt, rs must be zero
                6'h00: inst_r = (rs_field == '0) ? INST_SLL : INST_INVALID;
                6'h02: inst_r = (rs_field == '0) ? INST_SRL : INST_INVALID;
                6'h03: inst_r = (rs_field == '0) ? INST_SRA : INST_INVALID;
                6'h04: inst_r = INST_SLLV;
                6'h06: inst_r = INST_SRLV;
                6'h07: inst_r = INST_SRAV;
                6'h08: inst_r = INST_JR;
                6'h09: inst_r = INST_JALR;
                6'h0c: inst_r = INST_SYSCALL;
                6'h0d: inst_r = INST_BREAK;
                6'h10: inst_r = INST_MFHI;
                6'h11: inst_r = INST_MTHI;
                6'h12: inst_r = INST_MFLO;
                6'h13: inst_r = INST_MTLO;
                6'h18: inst_r = INST_MULT;
                6'h19: inst_r = INST_MULTU;
                6'h1a: inst_r = INST_DIV;
                6'h1b: inst_r = INST_DIVU;
                6'h20: inst_r = INST_ADD;
                6'h21: inst_r = INST_ADDU;
                6'h22: inst_r = INST_SUB;
                6'h23: inst_r = INST_SUBU;
                6'h24: inst_r = INST_AND;
                6'h25: inst_r = INST_OR;
                6'h26: inst_r = INST_XOR;
                6'h27: inst_r = INST_NOR;
                6'h2a: inst_r = INST_SLT;
                6'h2b: inst_r = INST_SLTU;
                default: inst_r = INST_INVALID;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: id_i.sv
/* I-type decoder */
`timescale 1ns/100ps
`default_nettype none

module id_i
    import mips_isa_pkg::*, id_dec_pkg::*;
(
    // decode is purely combinational, clock and reset not used
    input  logic       clk,
    input  logic       arst_n,
    input  inst_code_t inst_code,
    output inst_t      inst_i,
    output reg_idx_t   reg_s,
    output reg_idx_t   reg_t,
    output imm16_t     immediate
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode = inst_code[31:26];
    assign funct  = inst_code[5:0];

    // field slices shared by every format
    assign reg_s     = inst_code[25:21];
    assign reg_t     = inst_code[20:16];
    assign immediate = inst_code[15:0];

    always_comb
    begin
        case (opcode)
            // REGIMM, selected by rt
            6'h01:
            begin
                case (reg_t)
                    5'h00: inst_i = INST_BLTZ;
                    5'h01: inst_i = INST_BGEZ;
                    5'h10: inst_i = INST_BLTZAL;
                    5'h11: inst_i = INST_BGEZAL;
                    default: inst_i = INST_INVALID;
                endcase
            end
            6'h04: inst_i = INST_BEQ;
            6'h05: inst_i = INST_BNE;
            6'h06: inst_i = INST_BLEZ;
            6'h07: inst_i = INST_BGTZ;
            6'h08: inst_i = INST_ADDI;
            6'h09: inst_i = INST_ADDIU;
            6'h0a: inst_i = INST_SLTI;
            6'h0b: inst_i = INST_SLTIU;
            6'h0c: inst_i = INST_ANDI;
            6'h0d: inst_i = INST_ORI;
            6'h0e: inst_i = INST_XORI;
            6'h0f: inst_i = INST_LUI;
            // COP0, moves by rs
            6'h10:
            begin
                if (reg_s == 5'h00)
                    inst_i = INST_MFC0;
                else if (reg_s == 5'h04)
                    inst_i = INST_MTC0;
                // CO bit set, op in funct
                else if (inst_code[25])
                begin
                    case (funct)
                        6'h01: inst_i = INST_TLBR;
                        6'h02: inst_i = INST_TLBWI;
                        6'h08: inst_i = INST_TLBP;
                        6'h18: inst_i = INST_ERET;
                        6'h20: inst_i = INST_WAIT;
                        default: inst_i = INST_INVALID;
                    endcase
                end
                else
                    inst_i = INST_INVALID;
            end
            // loads
            6'h20: inst_i = INST_LB;
            6'h21: inst_i = INST_LH;
            6'h22: inst_i = INST_LWL;
            6'h23: inst_i = INST_LW;
            6'h24: inst_i = INST_LBU;
            6'h25: inst_i = INST_LHU;
            6'h26: inst_i = INST_LWR;
            // stores
            6'h28: inst_i = INST_SB;
            6'h29: inst_i = INST_SH;
            6'h2a: inst_i = INST_SWL;
            6'h2b: inst_i = INST_SW;
            6'h2e: inst_i = INST_SWR;
            6'h2f: inst_i = INST_CACHE;
            6'h33: inst_i = INST_PREF;
            default: inst_i = INST_INVALID;
        endcase
    end

endmodule

`default_nettype wire

// File: id_merge.sv
/* decode merge and output register */
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module id_merge
    import mips_isa_pkg::*, id_dec_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       inst_valid,
    input  inst_code_t inst_code,
    input  inst_t      inst_r,
    input  inst_t      inst_i,
    input  reg_idx_t   reg_s,
    input  reg_idx_t   reg_t,
    input  imm16_t     immediate,
    output logic       dec_valid,
    output inst_t      inst,
    output inst_fmt_t  fmt,
    output reg_idx_t   rs,
    output reg_idx_t   rt,
    output reg_idx_t   rd,
    output shamt_t     shamt,
    output word_t      imm_ext,
    output jtarget_t   jtarget
);

    opcode_t   opcode;
    inst_t     inst_sel;
    inst_fmt_t fmt_grp;
    inst_fmt_t fmt_sel;
    word_t     imm_sel;

    assign opcode = inst_code[31:26];

    // format group by opcode and J/JAL decode
    always_comb
    begin
        case (opcode)
            6'h00:
            begin
                fmt_grp  = FMT_R;
                inst_sel = inst_r;
            end
            6'h02, 6'h03:
            begin
                fmt_grp  = FMT_J;
                inst_sel = opcode[0] ? INST_JAL : INST_J;
            end
            default:
            begin
                fmt_grp  = FMT_I;
                inst_sel = inst_i;
            end
        endcase
    end

    assign fmt_sel = (inst_sel == INST_INVALID) ? FMT_NONE : fmt_grp;

    // immediate extension is zero outside valid I-type
    always_comb
    begin
        imm_sel = '0;
        if (fmt_sel == FMT_I)
        begin
            case (inst_sel)
                INST_ANDI, INST_ORI, INST_XORI:
                    imm_sel = {{(`DATA_W-`IMM_W){1'b0}}, immediate};
                INST_LUI:
                    imm_sel = {immediate, {(`DATA_W-`IMM_W){1'b0}}};
                default:
                    imm_sel = {{(`DATA_W-`IMM_W){immediate[`IMM_W-1]}}, immediate};
            endcase
        end
    end

    // fields hold between strobes
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dec_valid <= 1'b0;
            inst      <= INST_INVALID;
            fmt       <= FMT_NONE;
            rs        <= '0;
            rt        <= '0;
            rd        <= '0;
            shamt     <= '0;
            imm_ext   <= '0;
            jtarget   <= '0;
        end
        else
        begin
            dec_valid <= inst_valid;
            if (inst_valid)
            begin
                inst    <= inst_sel;
                fmt     <= fmt_sel;
                rs      <= reg_s;
                rt      <= reg_t;
                rd      <= inst_code[15:11];
                shamt   <= inst_code[10:6];
                imm_ext <= imm_sel;
                jtarget <= inst_code[25:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: id_top.sv
/* instruction decode top */
`timescale 1ns/100ps
`default_nettype none

module id_top
    import mips_isa_pkg::*, id_dec_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       inst_valid,
    input  inst_code_t inst_code,
    output logic       dec_valid,
    output inst_t      inst,
    output inst_fmt_t  fmt,
    output reg_idx_t   rs,
    output reg_idx_t   rt,
    output reg_idx_t   rd,
    output shamt_t     shamt,
    output word_t      imm_ext,
    output jtarget_t   jtarget
);

    inst_t    inst_r;
    inst_t    inst_i;
    reg_idx_t reg_s;
    reg_idx_t reg_t;
    imm16_t   immediate;

    // peer decoders on the same word
    id_r i_id_r (
        .inst_code (inst_code),
        .inst_r    (inst_r)
    );

    id_i i_id_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_code (inst_code),
        .inst_i    (inst_i),
        .reg_s     (reg_s),
        .reg_t     (reg_t),
        .immediate (immediate)
    );

    id_merge i_id_merge (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst_code  (inst_code),
        .inst_r     (inst_r),
        .inst_i     (inst_i),
        .reg_s      (reg_s),
        .reg_t      (reg_t),
        .immediate  (immediate),
        .dec_valid  (dec_valid),
        .inst       (inst),
        .fmt        (fmt),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .shamt      (shamt),
        .imm_ext    (imm_ext),
        .jtarget    (jtarget)
    );

endmodule

`default_nettype wire

// File: tb_id_ref.svh
/* decode reference model and checks */
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

// expected identifier, format and extended immediate per the MIPS32 tables
function automatic void ref_decode(
    input  inst_code_t code,
    output inst_t      e_inst,
    output inst_fmt_t  e_fmt,
    output word_t      e_imm
);
    opcode_t  op;
    funct_t   fn;
    reg_idx_t rs_f;
    reg_idx_t rt_f;
    imm16_t   imm;

    op     = code[31:26];
    fn     = code[5:0];
    rs_f   = code[25:21];
    rt_f   = code[20:16];
    imm    = code[15:0];
    e_inst = INST_INVALID;
    e_fmt  = FMT_I;
    if (op == 6'h00)
    begin
        e_fmt = FMT_R;
        case (fn)
            6'h00: if (rs_f == 5'd0) e_inst = INST_SLL;
            6'h02: if (rs_f == 5'd0) e_inst = INST_SRL;
            6'h03: if (rs_f == 5'd0) e_inst = INST_SRA;
            6'h04: e_inst = INST_SLLV;
            6'h06: e_inst = INST_SRLV;
            6'h07: e_inst = INST_SRAV;
            6'h08: e_inst = INST_JR;
            6'h09: e_inst = INST_JALR;
            6'h0c: e_inst = INST_SYSCALL;
            6'h0d: e_inst = INST_BREAK;
            6'h10: e_inst = INST_MFHI;
            6'h11: e_inst = INST_MTHI;
            6'h12: e_inst = INST_MFLO;
            6'h13: e_inst = INST_MTLO;
            6'h18: e_inst = INST_MULT;
            6'h19: e_inst = INST_MULTU;
            6'h1a: e_inst = INST_DIV;
            6'h1b: e_inst = INST_DIVU;
            6'h20: e_inst = INST_ADD;
            6'h21: e_inst = INST_ADDU;
            6'h22: e_inst = INST_SUB;
            6'h23: e_inst = INST_SUBU;
            6'h24: e_inst = INST_AND;
            6'h25: e_inst = INST_OR;
            6'h26: e_inst = INST_XOR;
            6'h27: e_inst = INST_NOR;
            6'h2a: e_inst = INST_SLT;
            6'h2b: e_inst = INST_SLTU;
            default: e_inst = INST_INVALID;
        endcase
    end
    else if (op == 6'h02 || op == 6'h03)
    begin
        e_fmt  = FMT_J;
        e_inst = (op == 6'h02) ? INST_J : INST_JAL;
    end
    else if (op == 6'h01)
    begin
        case (rt_f)
            5'h00: e_inst = INST_BLTZ;
            5'h01: e_inst = INST_BGEZ;
            5'h10: e_inst = INST_BLTZAL;
            5'h11: e_inst = INST_BGEZAL;
            default: e_inst = INST_INVALID;
        endcase
    end
    else if (op == 6'h10)
    begin
        if (rs_f == 5'h00)
            e_inst = INST_MFC0;
        else if (rs_f == 5'h04)
            e_inst = INST_MTC0;
        // CO is the top bit of rs
        else if (rs_f[4])
        begin
            case (fn)
                6'h01: e_inst = INST_TLBR;
                6'h02: e_inst = INST_TLBWI;
                6'h08: e_inst = INST_TLBP;
                6'h18: e_inst = INST_ERET;
                6'h20: e_inst = INST_WAIT;
                default: e_inst = INST_INVALID;
            endcase
        end
    end
    else
    begin
        case (op)
            6'h04: e_inst = INST_BEQ;
            6'h05: e_inst = INST_BNE;
            6'h06: e_inst = INST_BLEZ;
            6'h07: e_inst = INST_BGTZ;
            6'h08: e_inst = INST_ADDI;
            6'h09: e_inst = INST_ADDIU;
            6'h0a: e_inst = INST_SLTI;
            6'h0b: e_inst = INST_SLTIU;
            6'h0c: e_inst = INST_ANDI;
            6'h0d: e_inst = INST_ORI;
            6'h0e: e_inst = INST_XORI;
            6'h0f: e_inst = INST_LUI;
            6'h20: e_inst = INST_LB;
            6'h21: e_inst = INST_LH;
            6'h22: e_inst = INST_LWL;
            6'h23: e_inst = INST_LW;
            6'h24: e_inst = INST_LBU;
            6'h25: e_inst = INST_LHU;
            6'h26: e_inst = INST_LWR;
            6'h28: e_inst = INST_SB;
            6'h29: e_inst = INST_SH;
            6'h2a: e_inst = INST_SWL;
            6'h2b: e_inst = INST_SW;
            6'h2e: e_inst = INST_SWR;
            6'h2f: e_inst = INST_CACHE;
            6'h33: e_inst = INST_PREF;
            default: e_inst = INST_INVALID;
        endcase
    end
    if (e_inst == INST_INVALID)
        e_fmt = FMT_NONE;
    // logical immediates zero-extend, LUI goes to the upper half
    e_imm = 32'h0;
    if (e_fmt == FMT_I)
    begin
        if (e_inst == INST_ANDI || e_inst == INST_ORI || e_inst == INST_XORI)
            e_imm = {16'h0000, imm};
        else if (e_inst == INST_LUI)
            e_imm = {imm, 16'h0000};
        else
            e_imm = {{16{imm[15]}}, imm};
    end
endfunction

task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
        $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        stop_on_failure();
    end
endtask

task automatic compare_inst(input string name, input inst_t actual, input inst_t expected);
    if (actual !== expected)
    begin
        $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        stop_on_failure();
    end
endtask

task automatic compare_fmt(input string name, input inst_fmt_t actual,
                           input inst_fmt_t expected);
    if (actual !== expected)
    begin
        $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        stop_on_failure();
    end
endtask

task automatic compare_reg(input string name, input reg_idx_t actual,
                           input reg_idx_t expected);
    if (actual !== expected)
    begin
        $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        stop_on_failure();
    end
endtask

task automatic compare_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected)
    begin
        $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        stop_on_failure();
    end
endtask

task automatic compare_target(input string name, input jtarget_t actual,
                              input jtarget_t expected);
    if (actual !== expected)
    begin
        $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        stop_on_failure();
    end
endtask

`endif

// File: tb_id_top.sv
/* instruction decode testbench */
`timescale 1ns/100ps
`default_nettype none

module tb_id_top
    import mips_isa_pkg::*, id_dec_pkg::*;
();

    localparam int RAND_WORDS   = 300;
    localparam int SPARSE_WORDS = 40;
    localparam int TAIL_WORDS   = 20;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       inst_valid;
    inst_code_t inst_code;
    logic       dec_valid;
    inst_t      inst;
    inst_fmt_t  fmt;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    shamt_t     shamt;
    word_t      imm_ext;
    jtarget_t   jtarget;

    // words in flight with the oldest at the front
    inst_code_t sent_q[$];
    inst_code_t dir_words[$];
    inst_code_t exp_code;
    inst_t      exp_inst;
    inst_fmt_t  exp_fmt;
    word_t      exp_imm;
    logic       have_last = 1'b0;
    logic       strobe_q;
    int         sent_count = 0;
    int         results_seen = 0;
    int         cycle_count = 0;
    int         cycle_limit = 1000000;
    integer     seed;

    task automatic stop_on_failure;
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    `include "tb_id_ref.svh"

    id_top i_id_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst_code  (inst_code),
        .dec_valid  (dec_valid),
        .inst       (inst),
        .fmt        (fmt),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .shamt      (shamt),
        .imm_ext    (imm_ext),
        .jtarget    (jtarget)
    );

    always #4 clk = ~clk;

    // strobe seen at each edge that dec_valid must match one cycle later
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            strobe_q <= 1'b0;
        else
            strobe_q <= inst_valid;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: test still running after %0d cycles", cycle_count);
            stop_on_failure();
        end
    end

    // outputs checked on the falling edge after they settle
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (dec_valid !== strobe_q)
            begin
                $display("dec_valid did not follow its strobe by exactly one cycle");
                stop_on_failure();
            end
            if (dec_valid)
            begin
                if (sent_q.size() == 0)
                begin
                    $display("dec_valid seen with no instruction word outstanding");
                    stop_on_failure();
                end
                exp_code = sent_q.pop_front();
                ref_decode(exp_code, exp_inst, exp_fmt, exp_imm);
                have_last = 1'b1;
                results_seen = results_seen + 1;
            end
            // while idle every field must hold the last result
            if (have_last)
            begin
                compare_inst("inst", inst, exp_inst);
                compare_fmt("fmt", fmt, exp_fmt);
                compare_reg("rs", rs, exp_code[25:21]);
                compare_reg("rt", rt, exp_code[20:16]);
                compare_reg("rd", rd, exp_code[15:11]);
                compare_reg("shamt", shamt, exp_code[10:6]);
                compare_word("imm_ext", imm_ext, exp_imm);
                compare_target("jtarget", jtarget, exp_code[25:0]);
            end
        end
    end

    function automatic inst_code_t encode_r(input reg_idx_t s, input reg_idx_t t,
                                            input reg_idx_t d, input shamt_t sa,
                                            input funct_t fn);
        return {6'h00, s, t, d, sa, fn};
    endfunction

    function automatic inst_code_t encode_i(input opcode_t op, input reg_idx_t s,
                                            input reg_idx_t t, input imm16_t imm);
        return {op, s, t, imm};
    endfunction

    task automatic send_word(input inst_code_t word);
        @(negedge clk);
        inst_valid = 1'b1;
        inst_code  = word;
        sent_q.push_back(word);
        sent_count = sent_count + 1;
    endtask

    // idle cycle with a changing word on the bus
    task automatic idle_cycle;
        @(negedge clk);
        inst_valid = 1'b0;
        inst_code  = $random(seed);
    endtask

    task automatic check_idle_after_reset;
        compare_bit("dec_valid", dec_valid, 1'b0);
        compare_inst("inst", inst, INST_INVALID);
    endtask

    initial
    begin
        int i;
        int gap;

        seed       = 37;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst_code  = '0;

        // every funct with rs zero and non-zero
        for (i = 0; i < 64; i++)
        begin
            dir_words.push_back(encode_r(5'd0, i[4:0], ~i[4:0], i[4:0] ^ 5'h15, i[5:0]));
            dir_words.push_back(encode_r(i[4:0] | 5'h01, ~i[4:0], i[4:0], 5'h0b, i[5:0]));
        end
        // every other opcode with negative and positive immediates
        for (i = 1; i < 64; i++)
        begin
            dir_words.push_back(encode_i(i[5:0], i[4:0] ^ 5'h0a, i[4:0], 16'h8a5c + i[15:0]));
            dir_words.push_back(encode_i(i[5:0], ~i[4:0], i[4:0] ^ 5'h13, 16'h35c7 + i[15:0]));
        end
        for (i = 0; i < 32; i++)
        begin
            dir_words.push_back(encode_i(6'h01, 5'h07, i[4:0], 16'hfff0 - i[15:0]));
            dir_words.push_back(encode_i(6'h10, i[4:0], 5'h0c, 16'h6000 | i[15:0]));
        end
        // COP0 with CO set, every funct
        for (i = 0; i < 64; i++)
            dir_words.push_back(encode_i(6'h10, 5'h10, 5'h00, {10'h000, i[5:0]}));

        // one extra word goes out just before the mid-run reset
        cycle_limit = (dir_words.size() + RAND_WORDS + SPARSE_WORDS + TAIL_WORDS + 1) * 3
                      + 100;

        repeat (4) idle_cycle();
        arst_n = 1'b1;
        repeat (2) idle_cycle();
        check_idle_after_reset();

        foreach (dir_words[i])
            send_word(dir_words[i]);
        idle_cycle();

        // back-to-back random stream
        repeat (RAND_WORDS) send_word($random(seed));
        idle_cycle();

        // sparse strobes with held fields in the gaps
        repeat (SPARSE_WORDS)
        begin
            send_word($random(seed));
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) idle_cycle();
        end
        repeat (3) idle_cycle();

        // asynchronous reset while a result is out
        send_word($random(seed));
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        sent_count = sent_count - sent_q.size();
        sent_q.delete();
        have_last = 1'b0;
        #1;
        check_idle_after_reset();
        repeat (4) idle_cycle();
        arst_n = 1'b1;
        repeat (2) idle_cycle();
        check_idle_after_reset();

        repeat (TAIL_WORDS) send_word($random(seed));
        while (sent_q.size() != 0)
            idle_cycle();
        repeat (2) idle_cycle();

        if (results_seen == sent_count)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("%0d results seen for %0d words sent", results_seen, sent_count);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
mips_isa_pkg.sv
id_dec_pkg.sv
id_r.sv
id_i.sv
id_merge.sv
id_top.sv
tb_id_top.sv

// File: Bender.yml
package:
  name: mips_id

export_include_dirs:
  - .

sources:
  - target: any(rtl, test)
    files:
      - mips_isa_pkg.sv
      - id_dec_pkg.sv
      - id_r.sv
      - id_i.sv
      - id_merge.sv
      - id_top.sv
  - target: test
    files:
      - tb_id_top.sv
